//--- logic/udp_echo_pkg.sv
// UDP echo package with payload widths, header field types and default echo settings
package udp_echo_pkg;

    // Payload word geometry
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [KEEP_WIDTH-1:0] keep_t;

    // Header field types
    typedef logic [31:0] ip_addr_t;

    // Also carries UDP length and checksum
    typedef logic [15:0] udp_port_t;

    // Echo service defaults
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;
    localparam ip_addr_t  DEFAULT_LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0] ECHO_TTL         = 8'd64;

    // Payload buffer depth as log2
    localparam int DEFAULT_FIFO_ADDR_WIDTH = 10;

endpackage

//--- logic/udp_echo_filter.sv
// UDP echo filter that keeps or drops frames by destination port and builds the reply header
module udp_echo_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP  = udp_echo_pkg::DEFAULT_LOCAL_IP
) (
    input  logic                      clk,
    input  logic                      rst,

    // Received UDP header
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t    rx_source_ip,
    input  udp_echo_pkg::udp_port_t   rx_source_port,
    input  udp_echo_pkg::udp_port_t   rx_dest_port,
    input  udp_echo_pkg::udp_port_t   rx_length,

    // Reply header
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t    tx_source_ip,
    output udp_echo_pkg::ip_addr_t    tx_dest_ip,
    output udp_echo_pkg::udp_port_t   tx_source_port,
    output udp_echo_pkg::udp_port_t   tx_dest_port,
    output udp_echo_pkg::udp_port_t   tx_length,
    output logic [7:0]                tx_ttl,
    output udp_echo_pkg::udp_port_t   tx_checksum,

    // Received payload
    input  udp_echo_pkg::data_t       rx_payload_data,
    input  udp_echo_pkg::keep_t       rx_payload_keep,
    input  logic                      rx_payload_valid,
    input  logic                      rx_payload_last,
    output logic                      rx_payload_ready,

    // Payload toward the buffer
    output udp_echo_pkg::data_t       fifo_in_data,
    output udp_echo_pkg::keep_t       fifo_in_keep,
    output logic                      fifo_in_valid,
    output logic                      fifo_in_last,
    input  logic                      fifo_in_ready
);

    import udp_echo_pkg::*;

    logic port_match;
    logic hdr_xfer;
    logic payload_xfer;

    // Set from header transfer until the last payload beat is taken
    logic frame_active;
    // Decision for the active frame, 1 means echo
    logic keep_frame;

    assign port_match = (rx_dest_port == ECHO_PORT);

    // Header side, only while no frame is in progress
    assign tx_hdr_valid = rx_hdr_valid && port_match && !frame_active;
    assign rx_hdr_ready = !frame_active && (!port_match || tx_hdr_ready);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;

    // Reply goes back to the sender
    assign tx_source_ip   = LOCAL_IP;
    assign tx_dest_ip     = rx_source_ip;
    assign tx_source_port = rx_dest_port;
    assign tx_dest_port   = rx_source_port;
    assign tx_length      = rx_length;
    assign tx_ttl         = ECHO_TTL;
    // No UDP checksum on replies
    assign tx_checksum    = '0;

    // Payload routing, kept beats to the FIFO, dropped beats sink every cycle
    assign fifo_in_data     = rx_payload_data;
    assign fifo_in_keep     = rx_payload_keep;
    assign fifo_in_last     = rx_payload_last;
    assign fifo_in_valid    = rx_payload_valid && frame_active && keep_frame;
    assign rx_payload_ready = frame_active && (!keep_frame || fifo_in_ready);
    assign payload_xfer     = rx_payload_valid && rx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_active <= 1'b0;
            keep_frame   <= 1'b0;
        end else if (hdr_xfer) begin
            frame_active <= 1'b1;
            keep_frame   <= port_match;
        end else if (payload_xfer && rx_payload_last) begin
            frame_active <= 1'b0;
            keep_frame   <= 1'b0;
        end
    end

endmodule

//--- logic/udp_payload_fifo.sv
// Synchronous payload FIFO with a registered output stage holding data, keep and last
module udp_payload_fifo #(
    parameter int FIFO_ADDR_WIDTH = udp_echo_pkg::DEFAULT_FIFO_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    input  udp_echo_pkg::data_t   in_data,
    input  udp_echo_pkg::keep_t   in_keep,
    input  logic                  in_valid,
    input  logic                  in_last,
    output logic                  in_ready,

    output udp_echo_pkg::data_t   out_data,
    output udp_echo_pkg::keep_t   out_keep,
    output logic                  out_valid,
    output logic                  out_last,
    input  logic                  out_ready
);

    import udp_echo_pkg::*;

    localparam int WORD_WIDTH = DATA_WIDTH + KEEP_WIDTH + 1;
    localparam int DEPTH      = 2 ** FIFO_ADDR_WIDTH;

    logic [WORD_WIDTH-1:0] mem [DEPTH];

    // Extra top bit tells full from empty
    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;

    logic mem_empty;
    logic mem_full;
    logic in_xfer;
    logic load_out;
    logic take_mem;
    logic bypass;
    logic wr_en;

    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_ptr == {~rd_ptr[FIFO_ADDR_WIDTH], rd_ptr[FIFO_ADDR_WIDTH-1:0]});
    assign in_ready  = !mem_full;
    assign in_xfer   = in_valid && in_ready;

    // Output stage is free when empty or being consumed
    assign load_out = !out_valid || out_ready;
    assign take_mem = load_out && !mem_empty;
    // Straight into the output stage when nothing is queued ahead
    assign bypass   = load_out && mem_empty && in_xfer;
    assign wr_en    = in_xfer && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (load_out) begin
                out_valid <= take_mem || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= {in_last, in_keep, in_data};
        end
        if (take_mem) begin
            {out_last, out_keep, out_data} <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
        end else if (bypass) begin
            {out_last, out_keep, out_data} <= {in_last, in_keep, in_data};
        end
    end

endmodule

//--- logic/echo_led_monitor.sv
// LED monitor latching the first payload byte of each reply frame
module echo_led_monitor (
    input  logic                  clk,
    input  logic                  rst,

    // Observed reply payload channel
    input  udp_echo_pkg::data_t   payload_data,
    input  logic                  payload_valid,
    input  logic                  payload_ready,
    input  logic                  payload_last,

    output logic [7:0]            led
);

    logic xfer;
    // Next transfer opens a new frame
    logic start_of_frame;

    assign xfer = payload_valid && payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_of_frame <= 1'b1;
            led            <= 8'd0;
        end else if (xfer) begin
            start_of_frame <= payload_last;
            if (start_of_frame) begin
                led <= payload_data[7:0];
            end
        end
    end

endmodule

//--- logic/udp_echo_top.sv
// UDP echo top level joining the port filter, payload FIFO and LED monitor
module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT       = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP        = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter int                      FIFO_ADDR_WIDTH = udp_echo_pkg::DEFAULT_FIFO_ADDR_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst,

    // UDP header from the stack
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t    rx_source_ip,
    input  udp_echo_pkg::udp_port_t   rx_source_port,
    input  udp_echo_pkg::udp_port_t   rx_dest_port,
    input  udp_echo_pkg::udp_port_t   rx_length,

    // UDP payload from the stack
    input  udp_echo_pkg::data_t       rx_payload_data,
    input  udp_echo_pkg::keep_t       rx_payload_keep,
    input  logic                      rx_payload_valid,
    input  logic                      rx_payload_last,
    output logic                      rx_payload_ready,

    // Reply header to the stack
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t    tx_source_ip,
    output udp_echo_pkg::ip_addr_t    tx_dest_ip,
    output udp_echo_pkg::udp_port_t   tx_source_port,
    output udp_echo_pkg::udp_port_t   tx_dest_port,
    output udp_echo_pkg::udp_port_t   tx_length,
    output logic [7:0]                tx_ttl,
    output udp_echo_pkg::udp_port_t   tx_checksum,

    // Reply payload to the stack
    output udp_echo_pkg::data_t       tx_payload_data,
    output udp_echo_pkg::keep_t       tx_payload_keep,
    output logic                      tx_payload_valid,
    output logic                      tx_payload_last,
    input  logic                      tx_payload_ready,

    output logic [7:0]                led
);

    import udp_echo_pkg::*;

    // Kept payload between filter and FIFO
    data_t fifo_in_data;
    keep_t fifo_in_keep;
    logic  fifo_in_valid;
    logic  fifo_in_last;
    logic  fifo_in_ready;

    udp_echo_filter #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP)
    ) u_filter (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_source_ip     (rx_source_ip),
        .rx_source_port   (rx_source_port),
        .rx_dest_port     (rx_dest_port),
        .rx_length        (rx_length),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_source_ip     (tx_source_ip),
        .tx_dest_ip       (tx_dest_ip),
        .tx_source_port   (tx_source_port),
        .tx_dest_port     (tx_dest_port),
        .tx_length        (tx_length),
        .tx_ttl           (tx_ttl),
        .tx_checksum      (tx_checksum),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_keep  (rx_payload_keep),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_ready (rx_payload_ready),
        .fifo_in_data     (fifo_in_data),
        .fifo_in_keep     (fifo_in_keep),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_last     (fifo_in_last),
        .fifo_in_ready    (fifo_in_ready)
    );

    udp_payload_fifo #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (fifo_in_data),
        .in_keep   (fifo_in_keep),
        .in_valid  (fifo_in_valid),
        .in_last   (fifo_in_last),
        .in_ready  (fifo_in_ready),
        .out_data  (tx_payload_data),
        .out_keep  (tx_payload_keep),
        .out_valid (tx_payload_valid),
        .out_last  (tx_payload_last),
        .out_ready (tx_payload_ready)
    );

    // Watches the reply payload without driving it
    echo_led_monitor u_led (
        .clk           (clk),
        .rst           (rst),
        .payload_data  (tx_payload_data),
        .payload_valid (tx_payload_valid),
        .payload_ready (tx_payload_ready),
        .payload_last  (tx_payload_last),
        .led           (led)
    );

endmodule

//--- dv/udp_echo_assert.sv
// Protocol assertions on the reply header and payload channels of the UDP echo top level
module udp_echo_assert #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    tx_hdr_valid,
    input logic                    tx_hdr_ready,
    input udp_echo_pkg::ip_addr_t  tx_dest_ip,
    input udp_echo_pkg::udp_port_t tx_source_port,
    input udp_echo_pkg::udp_port_t tx_dest_port,
    input udp_echo_pkg::udp_port_t tx_length,
    input udp_echo_pkg::data_t     tx_payload_data,
    input udp_echo_pkg::keep_t     tx_payload_keep,
    input logic                    tx_payload_valid,
    input logic                    tx_payload_ready,
    input logic                    tx_payload_last
);

    // Replies always leave from the echo port
    hdr_port_a: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid |-> tx_source_port == ECHO_PORT)
        else $error("Reply header source port is not the echo port");

    hdr_hold_a: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_dest_ip)
            && $stable(tx_dest_port) && $stable(tx_length))
        else $error("Reply header changed while stalled");

    payload_hold_a: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable(tx_payload_data)
            && $stable(tx_payload_keep) && $stable(tx_payload_last))
        else $error("Reply payload changed while stalled");

    // Both reply channels come out of reset idle
    reset_idle_a: assert property (@(posedge clk)
        $fell(rst) |-> !tx_hdr_valid && !tx_payload_valid)
        else $error("Reply channel valid right after reset");

endmodule

//--- dv/tb_udp_echo.sv
// Testbench for the UDP echo top level, replaying frames from a cases file against a reply model
module tb_udp_echo;

    import udp_echo_pkg::*;

    localparam int          MAX_CASES    = 32;
    localparam int          FIELDS       = 7;
    localparam int          RESET_CYCLES = 5;
    localparam int          IDLE_CYCLES  = 20;
    localparam int          TIMEOUT      = 2000;
    localparam logic [31:0] STALL_SEED   = 32'h16eb_89a3;
    // Shallow buffer so reply stalls fill it
    localparam int          FIFO_DEPTH_LOG2 = 2;

    logic       clk = 1'b0;
    logic       rst;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    ip_addr_t   rx_source_ip;
    udp_port_t  rx_source_port;
    udp_port_t  rx_dest_port;
    udp_port_t  rx_length;
    data_t      rx_payload_data;
    keep_t      rx_payload_keep;
    logic       rx_payload_valid;
    logic       rx_payload_last;
    logic       rx_payload_ready;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready = 1'b1;
    ip_addr_t   tx_source_ip;
    ip_addr_t   tx_dest_ip;
    udp_port_t  tx_source_port;
    udp_port_t  tx_dest_port;
    udp_port_t  tx_length;
    logic [7:0] tx_ttl;
    udp_port_t  tx_checksum;
    data_t      tx_payload_data;
    keep_t      tx_payload_keep;
    logic       tx_payload_valid;
    logic       tx_payload_last;
    logic       tx_payload_ready = 1'b1;
    logic [7:0] led;

    logic [31:0] case_mem [MAX_CASES*FIELDS];
    logic [1:0]  stall_mode;
    logic [31:0] stall_rng = STALL_SEED;

    // Echoed beats held off because the payload FIFO was full
    int          full_stalls = 0;

    // Reply model, in transfer order
    ip_addr_t   exp_dest_ip_q [$];
    udp_port_t  exp_dest_port_q [$];
    udp_port_t  exp_length_q [$];
    data_t      exp_data_q [$];
    keep_t      exp_keep_q [$];
    logic       exp_last_q [$];
    logic [7:0] model_led;
    logic       next_is_first;

    udp_echo_top #(
        .FIFO_ADDR_WIDTH (FIFO_DEPTH_LOG2)
    ) u_udp_echo_top (.*);

    bind udp_echo_top udp_echo_assert #(
        .ECHO_PORT (ECHO_PORT)
    ) u_assert (
        .clk              (clk),
        .rst              (rst),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_dest_ip       (tx_dest_ip),
        .tx_source_port   (tx_source_port),
        .tx_dest_port     (tx_dest_port),
        .tx_length        (tx_length),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_keep  (tx_payload_keep),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload_last  (tx_payload_last)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_reply_header();
        if (exp_dest_ip_q.size() == 0) begin
            abort_run("Reply header seen for a frame that should have been dropped");
        end
        check_equal("tx_source_ip", 64'(DEFAULT_LOCAL_IP), 64'(tx_source_ip));
        check_equal("tx_dest_ip", 64'(exp_dest_ip_q.pop_front()), 64'(tx_dest_ip));
        check_equal("tx_source_port", 64'(DEFAULT_ECHO_PORT), 64'(tx_source_port));
        check_equal("tx_dest_port", 64'(exp_dest_port_q.pop_front()), 64'(tx_dest_port));
        check_equal("tx_length", 64'(exp_length_q.pop_front()), 64'(tx_length));
        check_equal("tx_ttl", 64'd64, 64'(tx_ttl));
        check_equal("tx_checksum", 64'd0, 64'(tx_checksum));
    endtask

    task automatic check_reply_beat();
        data_t exp_data;
        logic  exp_last;
        if (exp_data_q.size() == 0) begin
            abort_run("Reply payload beat seen with no echoed beat pending");
        end
        exp_data = exp_data_q.pop_front();
        exp_last = exp_last_q.pop_front();
        check_equal("tx_payload_data", exp_data, tx_payload_data);
        check_equal("tx_payload_keep", 64'(exp_keep_q.pop_front()), 64'(tx_payload_keep));
        check_equal("tx_payload_last", 64'(exp_last), 64'(tx_payload_last));
        // LEDs follow one cycle after the first beat of a frame
        if (next_is_first) begin
            model_led = exp_data[7:0];
        end
        next_is_first = exp_last;
    endtask

    task automatic send_frame(input int idx);
        udp_port_t   dst_port;
        udp_port_t   length;
        int          beats;
        int          rem;
        int          k;
        int          cycles;
        logic [31:0] x;
        logic        echoed;
        keep_t       last_keep;
        data_t       frame_words [$];
        dst_port  = udp_port_t'(case_mem[idx*FIELDS+2]);
        length    = udp_port_t'(case_mem[idx*FIELDS+3]);
        beats     = int'(case_mem[idx*FIELDS+4]);
        x         = case_mem[idx*FIELDS+5];
        rem       = (int'(length) - 8) % 8;
        last_keep = (rem == 0) ? '1 : keep_t'((1 << rem) - 1);
        echoed    = (dst_port == DEFAULT_ECHO_PORT);
        if (echoed) begin
            exp_dest_ip_q.push_back(case_mem[idx*FIELDS]);
            exp_dest_port_q.push_back(udp_port_t'(case_mem[idx*FIELDS+1]));
            exp_length_q.push_back(length);
        end
        for (k = 0; k < beats; k++) begin
            x = xorshift32(x);
            frame_words.push_back({~x, x});
            if (echoed) begin
                exp_data_q.push_back({~x, x});
                exp_keep_q.push_back((k == beats - 1) ? last_keep : '1);
                exp_last_q.push_back(k == beats - 1);
            end
        end

        stall_mode     <= case_mem[idx*FIELDS+6][1:0];
        rx_hdr_valid   <= 1'b1;
        rx_source_ip   <= case_mem[idx*FIELDS];
        rx_source_port <= udp_port_t'(case_mem[idx*FIELDS+1]);
        rx_dest_port   <= dst_port;
        rx_length      <= length;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("Timed out waiting for the request header to be taken");
            end
        end while (!rx_hdr_ready);
        rx_hdr_valid <= 1'b0;

        for (k = 0; k < beats; k++) begin
            rx_payload_valid <= 1'b1;
            rx_payload_data  <= frame_words[k];
            rx_payload_keep  <= (k == beats - 1) ? last_keep : '1;
            rx_payload_last  <= (k == beats - 1);
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                // Dropped beats are sunk without waiting
                if (!echoed) begin
                    check_equal("rx_payload_ready", 64'd1, 64'(rx_payload_ready));
                end else if (!rx_payload_ready) begin
                    full_stalls++;
                end
                if (cycles > TIMEOUT) begin
                    abort_run("Timed out waiting for a request payload beat to be taken");
                end
            end while (!rx_payload_ready);
        end
        rx_payload_valid <= 1'b0;
        rx_payload_last  <= 1'b0;
    endtask

    // Random back-pressure on the reply side
    always @(posedge clk) begin
        stall_rng = xorshift32(stall_rng);
        tx_hdr_ready     <= !stall_mode[0] || stall_rng[0];
        tx_payload_ready <= !stall_mode[1] || (stall_rng[5:4] != 2'b00);
    end

    always @(posedge clk) begin
        if (rst) begin
            model_led     = 8'd0;
            next_is_first = 1'b1;
        end else begin
            check_equal("led", 64'(model_led), 64'(led));
            if (tx_hdr_valid && tx_hdr_ready) begin
                check_reply_header();
            end
            if (tx_payload_valid && tx_payload_ready) begin
                check_reply_beat();
            end
        end
    end

    initial begin
        int i;
        int n_cases;
        int cycles;
        rst              = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_source_ip     = '0;
        rx_source_port   = '0;
        rx_dest_port     = '0;
        rx_length        = '0;
        rx_payload_data  = '0;
        rx_payload_keep  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        stall_mode       = 2'd0;
        for (i = 0; i < MAX_CASES * FIELDS; i++) begin
            case_mem[i] = '0;
        end
        $readmemh("dv/udp_echo_cases.txt", case_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_equal("rx_hdr_ready", 64'd1, 64'(rx_hdr_ready));

        // A zero beat count ends the list
        n_cases = 0;
        while (n_cases < MAX_CASES && case_mem[n_cases*FIELDS+4] != '0) begin
            send_frame(n_cases);
            n_cases++;
        end
        if (n_cases == 0) begin
            abort_run("No frames were read from the cases file");
        end

        stall_mode <= 2'd0;
        cycles = 0;
        while (exp_data_q.size() != 0 || exp_dest_ip_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("Timed out waiting for the echoed frames to drain");
            end
        end
        // Quiet window catches duplicated beats
        repeat (IDLE_CYCLES) @(posedge clk);
        if (full_stalls == 0) begin
            abort_run("The payload FIFO never filled under reply back-pressure");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

//--- udp_echo_top.f
logic/udp_echo_pkg.sv
logic/udp_echo_filter.sv
logic/udp_payload_fifo.sv
logic/echo_led_monitor.sv
logic/udp_echo_top.sv
dv/udp_echo_assert.sv
dv/tb_udp_echo.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_udp_echo
FILELIST  = udp_echo_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

SOURCES   = $(shell cat $(FILELIST))
SIM       = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/udp_echo_cases.txt
// One request frame per line, all fields hex:
// src_ip src_port dst_port length beats payload_seed stall (bit0 tx_hdr_ready, bit1 tx_payload_ready)
c0a8010a 1388 04d2 0010 01 0badcafe 0
c0a8010b 9c40 04d2 0023 04 12345678 0
0a000001 0035 0050 0018 02 deadbeef 0
c0a80114 c350 04d2 0009 01 a5a5a5a5 1
ac100002 1f90 04d3 0030 05 0f1e2d3c 2
c0a80132 2710 04d2 0108 20 13579bdf 2
c0a80133 2711 04d2 0051 0a 2468ace0 3
0a0a0a0a ffff 0000 000c 01 77777777 3
c0a80140 4e20 04d2 0208 40 cafef00d 2
c0a80141 4e21 04d2 000f 01 31415926 1
c0a80142 4e22 04d2 0046 08 27182818 3
c0a80143 0007 04d2 0028 04 facefeed 0
// End of list
0 0 0 0 0 0 0
